/* common/shiftadd_defs.svh */
`ifndef SHIFTADD_DEFS_SVH
`define SHIFTADD_DEFS_SVH

// Operand and modulus width
`define SA_DATA_W 64

// Bit length field, holds 0 to 64
`define SA_LEN_W 7

// Cycle bound for each wait on a result
`define SA_TIMEOUT 20000

`endif

/* common/shiftadd_pkg.sv */
`include "shiftadd_defs.svh"

package shiftadd_pkg;

  typedef logic [`SA_DATA_W-1:0] data_t;
  typedef logic [`SA_LEN_W-1:0]  len_t;

  // Reduction request, x mod m
  typedef struct packed {
    data_t x;
    data_t m;
  } req_t;

  // Operand bundle for one core pass
  typedef struct packed {
    data_t x;
    data_t m;
    len_t  m_bl;  // Bit length of m
  } core_op_t;

  typedef enum logic [1:0] {
    LOAD,
    REDUCE,
    FINISH
  } red_state_t;

endpackage : shiftadd_pkg

/* project.f */
+incdir+common
common/shiftadd_pkg.sv
rtl/modulus_bitlen.sv
shiftadd/shiftadd_serialized.sv
shiftadd/shiftadd_serial_top.sv
rtl/mod_reduce_top.sv
testbench/tb_mod_reduce.sv

/* rtl/mod_reduce_top.sv */
`timescale 1ns/10ps

module mod_reduce_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  shiftadd_pkg::req_t  req_i,
  output shiftadd_pkg::data_t result_o,
  output logic                valid_o,
  output logic                busy_o
);
  import shiftadd_pkg::*;

  req_t req_q;
  len_t m_bl;
  logic start_acc;
  logic start_d1_q;
  logic start_d2_q;
  logic busy_q;

  assign start_acc = start_i && !busy_q;         // Start while busy is dropped

  always_ff @(posedge clk_i) begin
    if (start_acc) begin
      req_q <= req_i;
    end
  end

  // Delay start until m_bl is registered
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_d1_q <= 1'b0;
      start_d2_q <= 1'b0;
      busy_q     <= 1'b0;
    end else begin
      start_d1_q <= start_acc;
      start_d2_q <= start_d1_q;
      if (start_acc) begin
        busy_q <= 1'b1;
      end else if (valid_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  modulus_bitlen i_modulus_bitlen (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .m_i    (req_q.m),
    .m_bl_o (m_bl)
  );

  shiftadd_serial_top i_shiftadd_serial_top (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_d2_q),
    .x_i      (req_q.x),
    .m_i      (req_q.m),
    .m_bl_i   (m_bl),
    .result_o (result_o),
    .valid_o  (valid_o)
  );

  assign busy_o = busy_q;

endmodule : mod_reduce_top

/* rtl/modulus_bitlen.sv */
`timescale 1ns/10ps
`include "shiftadd_defs.svh"

module modulus_bitlen (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  shiftadd_pkg::data_t m_i,
  output shiftadd_pkg::len_t  m_bl_o
);
  import shiftadd_pkg::*;

  len_t bl_d;
  len_t bl_q;

  // Highest set bit wins
  always_comb begin
    bl_d = '0;
    for (int i = 0; i < `SA_DATA_W; i++) begin
      if (m_i[i]) begin
        bl_d = len_t'(i + 1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bl_q <= '0;
    end else begin
      bl_q <= bl_d;
    end
  end

  assign m_bl_o = bl_q;

  // A newly latched modulus must be nonzero
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$stable(m_i) |-> (m_i != '0));

endmodule : modulus_bitlen

/* run_sim.sh */
#!/bin/sh
# Compile and run the mod_reduce testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f project.f \
  --top-module tb_mod_reduce \
  -o sim_mod_reduce > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_mod_reduce > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* shiftadd/shiftadd_serial_top.sv */
`timescale 1ns/10ps

module shiftadd_serial_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  shiftadd_pkg::data_t x_i,
  input  shiftadd_pkg::data_t m_i,
  input  shiftadd_pkg::len_t  m_bl_i,
  output shiftadd_pkg::data_t result_o,
  output logic                valid_o
);
  import shiftadd_pkg::*;

  red_state_t state_q;
  red_state_t state_d;

  logic     was_reduce_q;
  logic     entered_reduce;
  logic     recurse_cond;
  logic     recurse_cond_q;
  logic     recurse_pulse;
  logic     trigger_start;
  logic     start_hold_q;
  logic     core_start;
  logic     core_valid;
  logic     done;
  data_t    core_res;
  data_t    operand_q;
  data_t    result_q;
  core_op_t core_op;

  assign recurse_cond   = (state_q == REDUCE) && core_valid && (core_res >= m_i);
  assign recurse_pulse  = recurse_cond && !recurse_cond_q;
  assign entered_reduce = (state_q == REDUCE) && !was_reduce_q;
  assign trigger_start  = entered_reduce || recurse_pulse;
  // Two-cycle start, the second cycle sees the updated operand
  assign core_start     = trigger_start || start_hold_q;
  assign done           = (state_q == REDUCE) && core_valid && (core_res < m_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      LOAD: begin
        if (start_i) begin
          state_d = REDUCE;
        end
      end
      REDUCE: begin
        if (done) begin
          state_d = FINISH;
        end
      end
      FINISH:  state_d = LOAD;
      default: state_d = LOAD;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= LOAD;
      was_reduce_q   <= 1'b0;
      recurse_cond_q <= 1'b0;
      start_hold_q   <= 1'b0;
    end else begin
      state_q        <= state_d;
      was_reduce_q   <= (state_q == REDUCE);
      recurse_cond_q <= recurse_cond;
      start_hold_q   <= trigger_start;
    end
  end

  // Each partial result becomes the next operand
  always_ff @(posedge clk_i) begin
    if (core_valid) begin
      operand_q <= core_res;
    end else if ((state_q == LOAD) && start_i) begin
      operand_q <= x_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_q <= '0;
    end else if (done) begin
      result_q <= core_res;                      // Held until next reduction ends
    end
  end

  assign core_op.x    = operand_q;
  assign core_op.m    = m_i;
  assign core_op.m_bl = m_bl_i;

  shiftadd_serialized i_shiftadd_serialized (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (core_start),
    .op_i     (core_op),
    .result_o (core_res),
    .valid_o  (core_valid)
  );

  assign result_o = result_q;
  assign valid_o  = (state_q == FINISH);

  // Core results only arrive during a reduction
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_valid |-> (state_q == REDUCE));

endmodule : shiftadd_serial_top

/* shiftadd/shiftadd_serialized.sv */
`timescale 1ns/10ps

module shiftadd_serialized (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  shiftadd_pkg::core_op_t op_i,
  output shiftadd_pkg::data_t  result_o,
  output logic                 valid_o
);
  import shiftadd_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    SCAN,
    ALIGN,
    SUB,
    DONE
  } core_state_t;

  core_state_t state_q;
  core_op_t    op_q;
  data_t       scan_q;
  len_t        len_q;
  data_t       sub_q;
  data_t       result_q;
  data_t       shifted_m;
  data_t       sub_d;

  // Largest shifted copy of m not above x
  always_comb begin
    shifted_m = op_q.m << (len_q - op_q.m_bl);
    if (len_q < op_q.m_bl) begin
      sub_d = '0;                              // x already below m
    end else if (shifted_m > op_q.x) begin
      if (len_q == op_q.m_bl) begin
        sub_d = '0;
      end else begin
        sub_d = shifted_m >> 1;
      end
    end else begin
      sub_d = shifted_m;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= SCAN;
          end
        end
        SCAN: begin
          if (scan_q == '0) begin
            state_q <= ALIGN;
          end
        end
        ALIGN:   state_q <= SUB;
        SUB:     state_q <= DONE;
        DONE:    state_q <= IDLE;                // Start ignored here
        default: state_q <= IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk_i) begin
    case (state_q)
      IDLE: begin
        if (start_i) begin
          op_q   <= op_i;
          scan_q <= op_i.x;
          len_q  <= '0;
        end
      end
      SCAN: begin
        if (scan_q != '0) begin
          scan_q <= scan_q >> 1;
          len_q  <= len_q + len_t'(1);           // One bit per cycle
        end
      end
      ALIGN: begin
        sub_q <= sub_d;
      end
      SUB: begin
        result_q <= op_q.x - sub_q;
      end
      default: begin
      end
    endcase
  end

  assign result_o = result_q;
  assign valid_o  = (state_q == DONE);

  // Subtraction never wraps below zero
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> (result_o <= op_q.x));

endmodule : shiftadd_serialized

/* testbench/mod_reduce_vectors.txt */
# Columns: test name, x, m, expected x mod m
# Values are hexadecimal, one test per line
lt_m           0000000000000005 0000000000000007 0000000000000005
lt_m_near      0000000000000100 0000000000000101 0000000000000100
eq_m           00000000000004d2 00000000000004d2 0000000000000000
x_zero         0000000000000000 0000000000000005 0000000000000000
x_m_plus1      0000000000001001 0000000000001000 0000000000000001
dec_hundred    0000000000000064 000000000000000a 0000000000000000
dec_hundred1   0000000000000065 000000000000000a 0000000000000001
dec_thousand   00000000000003e8 0000000000000007 0000000000000006
pow2_24_m3     0000000001000000 0000000000000003 0000000000000001
big_x_m3       ffffffffffffffff 0000000000000003 0000000000000000
big_x_m7       ffffffffffffffff 0000000000000007 0000000000000001
big_x_m17      ffffffffffffffff 0000000000000011 0000000000000000
big_x_mff      ffffffffffffffff 00000000000000ff 0000000000000000
big_x_m32ones  ffffffffffffffff 00000000ffffffff 0000000000000000
m_one          ffffffffffffffff 0000000000000001 0000000000000000
m_one_small    0000000000000abc 0000000000000001 0000000000000000
m_pow2_16      123456789abcdef0 0000000000010000 000000000000def0
m_pow2_32      123456789abcdef0 0000000100000000 000000009abcdef0
m_low_12       00000000deadbeef 0000000000001000 0000000000000eef
m_top          ffffffffffffffff 8000000000000000 7fffffffffffffff
m_top_lt       7fffffffffffffff 8000000000000000 7fffffffffffffff
m_top_eq       8000000000000000 8000000000000000 0000000000000000
m_top_one      8000000000000001 8000000000000000 0000000000000001

/* testbench/tb_mod_reduce.sv */
`timescale 1ns/10ps
`include "shiftadd_defs.svh"

module tb_mod_reduce;
  import shiftadd_pkg::*;

  logic  clk_i;
  logic  rst_ni;
  logic  start_i;
  req_t  req_i;
  data_t result_o;
  logic  valid_o;
  logic  busy_o;

  mod_reduce_top i_mod_reduce_top (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_i),
    .req_i    (req_i),
    .result_o (result_o),
    .valid_o  (valid_o),
    .busy_o   (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Next clock edge plus the drive skew
  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic compare_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      abort_run("wrong data value");
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
      abort_run("wrong control bit");
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic wait_valid(input string name);
    int cycles;
    cycles = 0;
    while (valid_o !== 1'b1) begin
      if (cycles >= `SA_TIMEOUT) begin
        abort_run($sformatf("timeout waiting for valid_o in test %s", name));
      end
      step();
      cycles++;
    end
  endtask

  task automatic start_request(input data_t x, input data_t m);
    req_i.x = x;
    req_i.m = m;
    start_i = 1'b1;
    step();
    start_i = 1'b0;
  endtask

  // Single valid cycle, then a held result and an idle unit
  task automatic check_result(input string name, input data_t exp);
    wait_valid(name);
    compare_data(name, exp, result_o);
    step();
    compare_bit({name, "_valid_pulse"}, 1'b0, valid_o);
    repeat (3) begin
      compare_data({name, "_held"}, exp, result_o);
      compare_bit({name, "_idle"}, 1'b0, busy_o);
      step();
    end
  endtask

  task automatic run_case(input string name, input data_t x, input data_t m, input data_t exp);
    start_request(x, m);
    compare_bit({name, "_busy"}, 1'b1, busy_o);
    check_result(name, exp);
  endtask

  initial begin
    int          fd;
    int          n;
    int          vec_count;
    string       line;
    string       name;
    data_t       vx;
    data_t       vm;
    data_t       vexp;
    data_t       rx;
    data_t       rm;
    logic [31:0] seed;
    logic [31:0] hi;

    start_i   = 1'b0;
    req_i     = '0;
    rst_ni    = 1'b0;
    vec_count = 0;
    seed      = 32'h26bb_c625;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    step();

    compare_bit("reset_valid", 1'b0, valid_o);
    compare_bit("reset_busy", 1'b0, busy_o);
    compare_data("reset_result", '0, result_o);

    fd = $fopen("testbench/mod_reduce_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the vector file");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %h", name, vx, vm, vexp);
        if (n == 4) begin
          run_case(name, vx, vm, vexp);
          vec_count++;
        end
      end
    end
    $fclose(fd);
    if (vec_count == 0) begin
      abort_run("no vectors were read from the vector file");
    end

    for (int i = 0; i < 200; i++) begin
      seed = lcg_next(seed);
      hi   = seed;
      seed = lcg_next(seed);
      rx   = {hi, seed};
      seed = lcg_next(seed);
      hi   = seed;
      seed = lcg_next(seed);
      rm   = {hi, seed};
      seed = lcg_next(seed);
      rm   = rm >> (seed[31:26]);                // Spread modulus sizes
      if (rm == '0) begin
        rm = 64'd1;
      end
      run_case($sformatf("rand_%0d", i), rx, rm, rx % rm);
    end

    // Second start while busy must not disturb the first request
    start_request(64'hffff_ffff_ffff_ffff, 64'd7);
    step();
    compare_bit("busy_during_run", 1'b1, busy_o);
    start_request(64'd100, 64'd8);
    check_result("start_while_busy", 64'd1);

    $display("TEST PASS");
    $finish;
  end

endmodule : tb_mod_reduce
